// File: hw/trojan_host_pkg.sv
// ************************************************************
// Trojan host shared types
// Data word, program address and decoded word definitions
// for the XOR decoder benchmark host
// ************************************************************

package trojan_host_pkg;

    // Encoded and decoded data words share one width
    typedef logic [15:0] word_t;

    // Program address space is 8K words
    typedef logic [12:0] prog_adr_t;

    // Decoder result as seen by the signature stage and the top level
    typedef struct packed {
        word_t data;
        logic  valid;
    } decoded_word_t;

    // Three-step decode sequence
    typedef enum logic [1:0] {
        ds_start  = 2'd0,
        ds_decode = 2'd1,
        ds_finish = 2'd2
    } decode_state_e;

    // Fixed descrambling mask
    parameter word_t XOR_MASK_DEFAULT = 16'h3AB9;

    // Probe pulses needed before the forced decode
    parameter int TRIGGER_COUNT_DEFAULT = 4;

endpackage

// File: hw/program_address_counter.sv
// ************************************************************
// Program address counter
// Free-running address while decoding is enabled, plus the
// rare probe condition and a registered address output
// ************************************************************
`timescale 1ns/1ps

module program_address_counter
    import trojan_host_pkg::*;
(
    input  logic      clk,
    input  logic      pon_rst_i,
    input  logic      decode_enable,
    output logic      probe,
    output prog_adr_t prog_adr_out
);

    prog_adr_t address_counter;

    // Advances only on enabled cycles, wraps at 8191
    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            address_counter <= '0;
        end else if (decode_enable) begin
            address_counter <= address_counter + 1'b1;
        end
    end

    // Rare condition: odd address in the upper half
    assign probe = address_counter[12] & address_counter[0];

    // Address seen outside, one cycle behind the counter
    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            prog_adr_out <= '0;
        end else begin
            prog_adr_out <= address_counter;
        end
    end

endmodule

// File: hw/trigger_seq_detector.sv
// ************************************************************
// Trigger sequence detector
// Counts probe pulses and fires a single-cycle trigger once
// the threshold is reached, then rearms
// ************************************************************
`timescale 1ns/1ps

module trigger_seq_detector
    import trojan_host_pkg::*;
#(
    parameter int TRIGGER_COUNT = TRIGGER_COUNT_DEFAULT
)(
    input  logic clk,
    input  logic pon_rst_i,
    input  logic probe,
    output logic trigger
);

    // Wide enough to hold the threshold itself
    localparam int CNT_W = $clog2(TRIGGER_COUNT + 1);

    logic [CNT_W-1:0] probe_count;
    logic             count_done;

    // Current sample completes the sequence
    assign count_done = probe && (probe_count == CNT_W'(TRIGGER_COUNT - 1));

    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            probe_count <= '0;
            trigger     <= 1'b0;
        end else begin
            trigger <= count_done;          // One cycle after the last sample
            if (count_done) begin
                probe_count <= '0;          // Rearm
            end else if (probe) begin
                probe_count <= probe_count + 1'b1;
            end
        end
    end

endmodule

// File: hw/xor_word_decoder.sv
// ************************************************************
// XOR word decoder
// Three-state decode sequence stepped by decode_enable, with
// a trigger override that forces an early masked decode
// ************************************************************
`timescale 1ns/1ps

module xor_word_decoder
    import trojan_host_pkg::*;
#(
    parameter word_t XOR_MASK = XOR_MASK_DEFAULT
)(
    input  logic          clk,
    input  logic          pon_rst_i,
    input  word_t         encoded_input,
    input  logic          decode_enable,
    input  logic          trigger,
    output decoded_word_t decoded
);

    decode_state_e decode_state;
    word_t         masked_word;

    assign masked_word = encoded_input ^ XOR_MASK;

    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            decoded.data  <= '0;
            decoded.valid <= 1'b0;
            decode_state  <= ds_start;
        end else if (trigger) begin
            // Forced decode, regardless of enable
            decoded.data  <= masked_word;
            decoded.valid <= 1'b1;
            decode_state  <= ds_finish;
        end else if (decode_enable) begin
            case (decode_state)
                ds_start: begin
                    decoded.data  <= '0;
                    decoded.valid <= 1'b0;
                    decode_state  <= ds_decode;
                end
                ds_decode: begin
                    decoded.data  <= masked_word;   // Word for this slot
                    decoded.valid <= 1'b1;
                    decode_state  <= ds_finish;
                end
                ds_finish: begin
                    decoded.valid <= 1'b0;
                    decode_state  <= ds_start;
                end
                default: begin
                    // Unused encoding falls back to start
                    decoded.valid <= 1'b0;
                    decode_state  <= ds_start;
                end
            endcase
        end else begin
            // Stalled, state and data hold
            decoded.valid <= 1'b0;
        end
    end

endmodule

// File: hw/decode_signature_stage.sv
// ************************************************************
// Decode signature stage
// Rotate-XOR signature and word count over the valid words
// ************************************************************
`timescale 1ns/1ps

module decode_signature_stage
    import trojan_host_pkg::*;
(
    input  logic          clk,
    input  logic          pon_rst_i,
    input  decoded_word_t decoded,
    output word_t         signature,
    output word_t         word_count
);

    word_t sig_rotated;

    // Rotate left by one bit
    assign sig_rotated = {signature[14:0], signature[15]};

    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            signature <= '0;
        end else if (decoded.valid) begin
            signature <= sig_rotated ^ decoded.data;
        end
    end

    // Count of valid words, forced ones included
    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            word_count <= '0;
        end else if (decoded.valid) begin
            word_count <= word_count + 1'b1;
        end
    end

endmodule

// File: hw/decoder_host_top.sv
// ************************************************************
// Decoder host top level
// Chains address counter, trigger detector, XOR decoder and
// signature stage of the trojan benchmark host
// ************************************************************
`timescale 1ns/1ps

module decoder_host_top
    import trojan_host_pkg::*;
#(
    parameter word_t XOR_MASK      = XOR_MASK_DEFAULT,
    parameter int    TRIGGER_COUNT = TRIGGER_COUNT_DEFAULT
)(
    input  logic      clk,
    input  logic      pon_rst_i,
    input  word_t     encoded_input,
    input  logic      decode_enable,
    output word_t     decoded_output,
    output logic      decode_valid,
    output prog_adr_t prog_adr_out,
    output word_t     signature,
    output word_t     word_count
);

    logic          probe;
    logic          trigger;
    decoded_word_t decoded;

    program_address_counter adr_cnt_inst (
        .clk           (clk),
        .pon_rst_i     (pon_rst_i),
        .decode_enable (decode_enable),
        .probe         (probe),
        .prog_adr_out  (prog_adr_out)
    );

    trigger_seq_detector #(
        .TRIGGER_COUNT (TRIGGER_COUNT)
    ) trig_det_inst (
        .clk       (clk),
        .pon_rst_i (pon_rst_i),
        .probe     (probe),
        .trigger   (trigger)
    );

    xor_word_decoder #(
        .XOR_MASK (XOR_MASK)
    ) decoder_inst (
        .clk           (clk),
        .pon_rst_i     (pon_rst_i),
        .encoded_input (encoded_input),
        .decode_enable (decode_enable),
        .trigger       (trigger),
        .decoded       (decoded)
    );

    decode_signature_stage sig_inst (
        .clk        (clk),
        .pon_rst_i  (pon_rst_i),
        .decoded    (decoded),
        .signature  (signature),
        .word_count (word_count)
    );

    // Straight from the decoder register
    assign decoded_output = decoded.data;
    assign decode_valid   = decoded.valid;

endmodule

// File: bench/decoder_host_tb.sv
// ************************************************************
// Decoder host testbench
// Random stimulus with enable gaps, a cycle reference model
// and an output compare after every clock edge
// ************************************************************
`timescale 1ns/1ps

module decoder_host_tb
    import trojan_host_pkg::*;
;

    localparam word_t MASK         = 16'h3AB9;
    localparam int    TRIG_CNT     = 4;
    localparam int    RST_CYCLES   = 8;
    localparam int    PH_NORMAL    = 300;
    localparam int    PH_GAPS      = 300;
    localparam int    PH_LONG      = 8000;   // Crosses 4096 and the 8191 wrap
    localparam int    PH_TAIL      = 200;
    localparam int    TOTAL_CYCLES = RST_CYCLES + PH_NORMAL + PH_GAPS + PH_LONG + PH_TAIL + 4;

    // Cycle state of the reference model
    typedef struct packed {
        prog_adr_t     adr;
        prog_adr_t     adr_out;
        logic [2:0]    pcnt;
        logic          trig;
        decode_state_e state;
        word_t         data;
        logic          valid;
        word_t         sig;
        word_t         cnt;
    } model_t;

    logic      clk;
    logic      pon_rst_i;
    word_t     encoded_input;
    logic      decode_enable;
    word_t     decoded_output;
    logic      decode_valid;
    prog_adr_t prog_adr_out;
    word_t     signature;
    word_t     word_count;

    integer seed = 52947;
    model_t model;
    int     trig_seen  = 0;
    int     wrap_seen  = 0;

    decoder_host_top #(
        .XOR_MASK      (MASK),
        .TRIGGER_COUNT (TRIG_CNT)
    ) decoder_host_top_inst (
        .clk            (clk),
        .pon_rst_i      (pon_rst_i),
        .encoded_input  (encoded_input),
        .decode_enable  (decode_enable),
        .decoded_output (decoded_output),
        .decode_valid   (decode_valid),
        .prog_adr_out   (prog_adr_out),
        .signature      (signature),
        .word_count     (word_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Next model state from the current one and this cycle's inputs
    function automatic model_t ref_step(input model_t cur, input logic rst,
                                        input word_t enc, input logic en);
        model_t nxt;
        logic   probe;
        logic   done;
        nxt = cur;
        if (rst) begin
            nxt = '0;
            nxt.state = ds_start;
        end else begin
            probe = cur.adr[12] && cur.adr[0];
            done  = probe && (cur.pcnt == 3'(TRIG_CNT - 1));
            nxt.trig = done;
            if (done) nxt.pcnt = 3'd0;
            else if (probe) nxt.pcnt = cur.pcnt + 3'd1;
            if (en) nxt.adr = cur.adr + 13'd1;
            nxt.adr_out = cur.adr;
            if (cur.valid) begin                            // Signature lags valid
                nxt.sig = {cur.sig[14:0], cur.sig[15]} ^ cur.data;
                nxt.cnt = cur.cnt + 16'd1;
            end
            if (cur.trig) begin
                nxt.data  = enc ^ MASK;
                nxt.valid = 1'b1;
                nxt.state = ds_finish;
            end else if (en) begin
                case (cur.state)
                    ds_start: begin
                        nxt.data  = '0;
                        nxt.valid = 1'b0;
                        nxt.state = ds_decode;
                    end
                    ds_decode: begin
                        nxt.data  = enc ^ MASK;
                        nxt.valid = 1'b1;
                        nxt.state = ds_finish;
                    end
                    default: begin
                        nxt.valid = 1'b0;
                        nxt.state = ds_start;
                    end
                endcase
            end else begin
                nxt.valid = 1'b0;                           // Stall holds state
            end
        end
        return nxt;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // Step the model on each edge, compare at the falling edge
    initial begin
        model = '0;
        forever begin
            @(posedge clk);
            model = ref_step(model, pon_rst_i, encoded_input, decode_enable);
            if (model.trig) trig_seen++;
            if (model.adr_out == 13'h1FFF) wrap_seen++;
            @(negedge clk);
            check_value("decoded_output", 32'(decoded_output), 32'(model.data));
            check_value("decode_valid", 32'(decode_valid), 32'(model.valid));
            check_value("prog_adr_out", 32'(prog_adr_out), 32'(model.adr_out));
            check_value("signature", 32'(signature), 32'(model.sig));
            check_value("word_count", 32'(word_count), 32'(model.cnt));
        end
    end

    // Gap mode drops enable in about one cycle out of four
    task automatic drive_cycles(input int n, input bit gaps);
        logic [31:0] rnd;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            rnd = $random(seed);
            encoded_input = rnd[15:0];
            rnd = $random(seed);
            decode_enable = gaps ? (rnd[1:0] != 2'b00) : 1'b1;
        end
    endtask

    initial begin
        pon_rst_i     = 1'b1;
        encoded_input = '0;
        decode_enable = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 pon_rst_i = 1'b0;
        drive_cycles(PH_NORMAL, 1'b0);
        drive_cycles(PH_GAPS, 1'b1);
        drive_cycles(PH_LONG, 1'b0);                        // Trigger region and wrap
        drive_cycles(PH_TAIL, 1'b1);
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("trigger_pulses_seen", 32'(trig_seen != 0), 32'd1);
        check_value("address_wrap_seen", 32'(wrap_seen != 0), 32'd1);
        $display("Testbench passed");
        $finish;
    end

    initial begin
        #((TOTAL_CYCLES + 500) * 10);
        $display("timeout: the test sequence did not finish in time");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: sources.f
hw/trojan_host_pkg.sv
hw/program_address_counter.sv
hw/trigger_seq_detector.sv
hw/xor_word_decoder.sv
hw/decode_signature_stage.sv
hw/decoder_host_top.sv
bench/decoder_host_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the decoder host testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=decoder_host_tb

verilator --binary --timing --top-module "$TOP" -Mdir "$OBJ" -f sources.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -q "Testbench failed" "$LOG"
status=$?
if [ "$status" -eq 0 ]; then
    echo "Failure reported in $LOG"
    exit 1
elif [ "$status" -ne 1 ]; then
    echo "Could not search $LOG"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
